/* dem_uart_16550.sv */
`timescale 1ns/1ns

module dem_uart_16550 (
  input  logic                         clk,
  input  logic                         rst_i,
  input  logic                         bus_req_i,      // held until ack.
  input  logic                         bus_write_i,
  input  dem_uart_pkg::uart_reg_addr_t bus_addr_i,
  input  dem_uart_pkg::uart_char_t     bus_wdata_i,
  output logic                         bus_ack_o,      // one cycle pulse.
  output dem_uart_pkg::uart_char_t     bus_rdata_o,
  output logic                         out_valid_o,    // tx char toward the engine.
  output dem_uart_pkg::uart_char_t     out_char_o,
  input  logic                         out_ready_i,
  input  logic                         in_valid_i,     // rx char from the engine.
  input  dem_uart_pkg::uart_char_t     in_char_i,
  output logic                         in_ready_o,
  input  logic                         drop_i,         // emulation off, discard tx.
  output logic                         irq_o
);

  import dem_uart_pkg::*;

  logic [1:0] ier;                                     // only two enables exist.
  logic       thr_full;                                // tx holding register busy.
  logic       tx_hold;                                 // out_valid already shown.
  logic       rbr_full;                                // data ready.
  uart_char_t rbr_char;

  logic       bus_go;                                  // request not yet served.
  logic       thr_wr;
  logic       rbr_rd;
  logic       ack_en;
  logic       int_rda;
  logic       int_thre;
  uart_char_t lsr;
  uart_char_t iir;
  uart_char_t rd_mux;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus handshake
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign bus_go = bus_req_i & ~bus_ack_o;              // ack high means already done.
  assign thr_wr = bus_go & bus_write_i & (bus_addr_i == REG_RBR_THR);
  assign rbr_rd = bus_go & ~bus_write_i & (bus_addr_i == REG_RBR_THR);
  assign ack_en = bus_go & ~(thr_wr & thr_full);       // thr write waits for space.

  always_ff @(posedge clk) begin
    if (rst_i) begin
      bus_ack_o <= 1'b0;
      ier       <= '0;
    end else begin
      bus_ack_o <= ack_en;
      if (ack_en && bus_write_i && (bus_addr_i == REG_IER)) begin
        ier <= bus_wdata_i[1:0];
      end
    end
  end

  // read data sampled on the acknowledged cycle.
  always_ff @(posedge clk) begin
    if (ack_en && !bus_write_i) begin
      bus_rdata_o <= rd_mux;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // transmit holding register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // once shown, valid stays up even if drop rises.
  assign out_valid_o = thr_full & (tx_hold | ~drop_i);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      thr_full <= 1'b0;
      tx_hold  <= 1'b0;
    end else begin
      if (out_valid_o && out_ready_i) begin
        thr_full <= 1'b0;                              // handed to the engine.
        tx_hold  <= 1'b0;
      end else if (out_valid_o) begin
        tx_hold  <= 1'b1;                              // engine busy, keep offering.
      end else if (thr_full && drop_i) begin
        thr_full <= 1'b0;                              // disabled, throw char away.
      end
      if (thr_wr && !thr_full) begin
        thr_full <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (thr_wr && !thr_full) begin
      out_char_o <= bus_wdata_i;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // receive buffer register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign in_ready_o = ~rbr_full;                       // one entry deep.

  always_ff @(posedge clk) begin
    if (rst_i) begin
      rbr_full <= 1'b0;
    end else begin
      if (rbr_rd) begin
        rbr_full <= 1'b0;                              // cpu consumed it.
      end
      if (in_valid_i && in_ready_o) begin
        rbr_full <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      rbr_char <= in_char_i;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // status, identification and interrupt
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign int_rda  = ier[IER_RDA] & rbr_full;
  assign int_thre = ier[IER_THRE] & ~thr_full;
  assign irq_o    = int_rda | int_thre;

  always_comb begin
    lsr           = '0;
    lsr[LSR_DR]   = rbr_full;
    lsr[LSR_THRE] = ~thr_full;
  end

  // rx data outranks thr empty.
  always_comb begin
    if (int_rda) begin
      iir = IIR_RDA;
    end else if (int_thre) begin
      iir = IIR_THRE;
    end else begin
      iir = IIR_NONE;
    end
  end

  always_comb begin
    case (bus_addr_i)
      REG_RBR_THR: rd_mux = rbr_char;
      REG_IER:     rd_mux = {6'b0, ier};
      REG_IIR:     rd_mux = iir;
      REG_LSR:     rd_mux = lsr;
      default:     rd_mux = '0;                        // unimplemented reads zero.
    endcase
  end

endmodule

/* dem_uart_ahb3.sv */
`timescale 1ns/1ns

module dem_uart_ahb3 (
  input  logic               clk,
  input  logic               rst_i,
  input  dii_pkg::dii_word_t id_i,
  input  dii_pkg::dii_flit   debug_in_i,
  output logic               debug_in_ready_o,
  output dii_pkg::dii_flit   debug_out_o,
  input  logic               debug_out_ready_i,
  output logic               irq_o,
  input  logic               ahb3_hsel_i,
  input  logic [15:0]        ahb3_haddr_i,
  input  logic [31:0]        ahb3_hwdata_i,
  input  logic               ahb3_hwrite_i,
  input  logic [1:0]         ahb3_htrans_i,
  output logic [31:0]        ahb3_hrdata_o,
  output logic               ahb3_hready_o,
  output logic               ahb3_hresp_o
);

  import dem_uart_pkg::*;

  logic           bus_req;
  logic           bus_write;
  uart_reg_addr_t bus_addr;
  uart_char_t     bus_wdata;
  logic           bus_ack;
  uart_char_t     bus_rdata;

  logic           out_valid;                           // register block to engine.
  uart_char_t     out_char;
  logic           out_ready;
  logic           in_valid;                            // engine to register block.
  uart_char_t     in_char;
  logic           in_ready;
  logic           drop;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ahb3 to request/acknowledge mapping
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign bus_req   = ahb3_hsel_i & ahb3_htrans_i[1];   // nonseq or seq.
  assign bus_addr  = ahb3_haddr_i[4:2];                // word aligned registers.
  assign bus_write = ahb3_hwrite_i;
  assign bus_wdata = ahb3_hwdata_i[7:0];

  assign ahb3_hrdata_o = {4{bus_rdata}};               // byte on every lane.
  assign ahb3_hready_o = bus_ack;
  assign ahb3_hresp_o  = 1'b0;                         // always okay.

  dem_uart_emul u_emul (
    .clk               (clk),
    .rst_i             (rst_i),
    .id_i              (id_i),
    .debug_in_i        (debug_in_i),
    .debug_in_ready_o  (debug_in_ready_o),
    .debug_out_o       (debug_out_o),
    .debug_out_ready_i (debug_out_ready_i),
    .out_valid_i       (out_valid),
    .out_char_i        (out_char),
    .out_ready_o       (out_ready),
    .in_valid_o        (in_valid),
    .in_char_o         (in_char),
    .in_ready_i        (in_ready),
    .drop_o            (drop)
  );

  dem_uart_16550 u_16550 (
    .clk         (clk),
    .rst_i       (rst_i),
    .bus_req_i   (bus_req),
    .bus_write_i (bus_write),
    .bus_addr_i  (bus_addr),
    .bus_wdata_i (bus_wdata),
    .bus_ack_o   (bus_ack),
    .bus_rdata_o (bus_rdata),
    .out_valid_o (out_valid),
    .out_char_o  (out_char),
    .out_ready_i (out_ready),
    .in_valid_i  (in_valid),
    .in_char_i   (in_char),
    .in_ready_o  (in_ready),
    .drop_i      (drop),
    .irq_o       (irq_o)
  );

endmodule

/* dem_uart_emul.sv */
`timescale 1ns/1ns

module dem_uart_emul (
  input  logic                     clk,
  input  logic                     rst_i,
  input  dii_pkg::dii_word_t       id_i,               // our source id on the link.
  input  dii_pkg::dii_flit         debug_in_i,
  output logic                     debug_in_ready_o,
  output dii_pkg::dii_flit         debug_out_o,
  input  logic                     debug_out_ready_i,
  input  logic                     out_valid_i,        // char from the register block.
  input  dem_uart_pkg::uart_char_t out_char_i,
  output logic                     out_ready_o,
  output logic                     in_valid_o,         // char toward the register block.
  output dem_uart_pkg::uart_char_t in_char_o,
  input  logic                     in_ready_i,
  output logic                     drop_o              // high while emulation is off.
);

  import dii_pkg::*;
  import dem_uart_pkg::*;

  typedef enum logic [2:0] {
    tx_idle,
    tx_dest,
    tx_src,
    tx_flags,
    tx_payload
  } tx_state_t;

  tx_state_t  tx_state;
  tx_state_t  tx_next;
  uart_char_t tx_char;                                 // char being packed.

  dii_idx_t   rx_cnt;                                  // position of the next rx flit.
  dii_type_t  rx_type;                                 // type of the packet in flight.
  logic       rx_take;
  logic       rx_end;
  logic       rx_last_pos;
  logic       emul_en;                                 // host controlled enable.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // transmit, one char becomes one event packet
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign out_ready_o = (tx_state == tx_idle);          // accept only between packets.

  always_comb begin
    tx_next = tx_state;
    case (tx_state)
      tx_idle:    tx_next = out_valid_i ? tx_dest : tx_idle;
      tx_dest:    tx_next = debug_out_ready_i ? tx_src : tx_dest;
      tx_src:     tx_next = debug_out_ready_i ? tx_flags : tx_src;
      tx_flags:   tx_next = debug_out_ready_i ? tx_payload : tx_flags;
      tx_payload: tx_next = debug_out_ready_i ? tx_idle : tx_payload;
      default:    tx_next = tx_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      tx_state <= tx_idle;
    end else begin
      tx_state <= tx_next;
    end
  end

  always_ff @(posedge clk) begin
    if (out_valid_i && out_ready_o) begin
      tx_char <= out_char_i;                           // latch on handshake.
    end
  end

  // flit word follows the state; held as long as ready stays low.
  always_comb begin
    debug_out_o.valid = (tx_state != tx_idle);
    debug_out_o.last  = (tx_state == tx_payload);
    case (tx_state)
      tx_dest:    debug_out_o.data = DII_HOST_ID;
      tx_src:     debug_out_o.data = id_i;
      tx_flags:   debug_out_o.data = {DII_TYPE_EVENT, 8'h00};
      tx_payload: debug_out_o.data = {8'h00, tx_char};
      default:    debug_out_o.data = '0;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // receive, parse host packets
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign debug_in_ready_o = ~in_valid_o;               // stall while a char waits.
  assign rx_take          = debug_in_i.valid & debug_in_ready_o;
  assign rx_last_pos      = (rx_cnt == DII_POS_PAYLOAD);
  assign rx_end           = debug_in_i.last | rx_last_pos;  // resync on last.

  always_ff @(posedge clk) begin
    if (rst_i) begin
      rx_cnt     <= '0;
      in_valid_o <= 1'b0;
      emul_en    <= 1'b0;                              // start disabled.
    end else begin
      if (in_valid_o && in_ready_i) begin
        in_valid_o <= 1'b0;                            // char handed over.
      end
      if (rx_take) begin
        rx_cnt <= rx_end ? '0 : rx_cnt + 1'b1;
        if (rx_last_pos) begin
          if (rx_type == DII_TYPE_EVENT) begin
            in_valid_o <= 1'b1;
          end else if (rx_type == DII_TYPE_CTRL) begin
            emul_en <= debug_in_i.data[0];
          end
          // other types fall through and are dropped.
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_take && (rx_cnt == DII_POS_FLAGS)) begin
      rx_type <= debug_in_i.data[DII_TYPE_LSB +: 8];
    end
    if (rx_take && rx_last_pos && (rx_type == DII_TYPE_EVENT)) begin
      in_char_o <= debug_in_i.data[7:0];               // char in the low byte.
    end
  end

  assign drop_o = ~emul_en;

endmodule

/* dem_uart_pkg.sv */
// uart register map and character types.
package dem_uart_pkg;

  typedef logic [7:0] uart_char_t;            // one character, also a register byte.
  typedef logic [2:0] uart_reg_addr_t;        // register index, word addressed.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // 16550 register offsets
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam uart_reg_addr_t REG_RBR_THR = 3'd0;  // rx buffer on read, tx holding on write.
  localparam uart_reg_addr_t REG_IER     = 3'd1;  // interrupt enable.
  localparam uart_reg_addr_t REG_IIR     = 3'd2;  // interrupt identification, read only.
  localparam uart_reg_addr_t REG_LSR     = 3'd5;  // line status, read only.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // status bits and identification codes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int LSR_DR   = 0;                // data ready.
  localparam int LSR_THRE = 5;                // tx holding register empty.

  // ier bit 0 enables data ready, bit 1 enables thr empty.
  localparam int IER_RDA  = 0;
  localparam int IER_THRE = 1;

  localparam uart_char_t IIR_NONE = 8'h01;    // no interrupt pending.
  localparam uart_char_t IIR_THRE = 8'h02;    // tx holding register empty.
  localparam uart_char_t IIR_RDA  = 8'h04;    // received data available.

endpackage

/* dem_uart_properties.sv */
`timescale 1ns/1ns

module dem_uart_properties (
  input logic clk,
  input logic rst_i,
  input logic bus_ack_i,
  input logic out_valid_i,
  input logic out_ready_i,
  input logic drop_i,
  input logic irq_i
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus and transmit channel handshakes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  ack_pulse: assert property (@(posedge clk) disable iff (rst_i)
    bus_ack_i |=> !bus_ack_i)
    else $error("bus_ack_o held high for more than one cycle");

  // a shown char stays offered until the engine takes it.
  out_hold: assert property (@(posedge clk) disable iff (rst_i)
    out_valid_i && !out_ready_i |=> out_valid_i)
    else $error("out_valid_o dropped before out_ready_i");

  out_no_rise_on_drop: assert property (@(posedge clk) disable iff (rst_i)
    $rose(out_valid_i) |-> !drop_i)
    else $error("out_valid_o rose while emulation is disabled");

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reset state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  irq_reset: assert property (@(posedge clk) rst_i |=> !irq_i)
    else $error("irq_o high after a reset cycle");

endmodule

/* dii_pkg.sv */
// debug interconnect definitions shared by the emulation engine and the top.
package dii_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // flit format
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [15:0] dii_word_t;            // one flit payload word.
  typedef logic [7:0]  dii_type_t;            // packet type, upper byte of flags.

  typedef struct packed {
    logic      valid;                         // flit present on the link.
    logic      last;                          // final flit of a packet.
    dii_word_t data;                          // flit word.
  } dii_flit;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // packet layout
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int DII_PKT_LEN = 4;             // dest, src, flags, payload.
  localparam int DII_IDX_W   = $clog2(DII_PKT_LEN);

  typedef logic [DII_IDX_W-1:0] dii_idx_t;    // flit position inside a packet.

  localparam dii_idx_t DII_POS_FLAGS   = dii_idx_t'(2);
  localparam dii_idx_t DII_POS_PAYLOAD = dii_idx_t'(DII_PKT_LEN - 1);
  localparam int       DII_TYPE_LSB    = 8;   // type code sits in flags[15:8].

  localparam dii_type_t DII_TYPE_EVENT = 8'h02;   // character event.
  localparam dii_type_t DII_TYPE_CTRL  = 8'h03;   // host control write.

  localparam dii_word_t DII_HOST_ID = 16'h0000;   // all events go to the host.

endpackage

/* flist.f */
dii_pkg.sv
dem_uart_pkg.sv
dem_uart_emul.sv
dem_uart_16550.sv
dem_uart_ahb3.sv
dem_uart_properties.sv
tb_clkgen.sv
tb_dem_uart.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with verilator, run it and decide the result from the log.
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_dem_uart -f flist.f -o sim_dem_uart

./obj_dir/sim_dem_uart | tee sim.log

if grep -qx "sim passed" sim.log; then
  echo "result: pass"
else
  echo "result: fail"
  exit 1
fi

/* tb_clkgen.sv */
`timescale 1ns/1ns

module tb_clkgen (
  output logic clk_o,
  output logic rst_o
);

  localparam int HALF_PERIOD = 5;                      // 10 ns clock.
  localparam int RST_CYCLES  = 10;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;                                     // released on an edge, like any input.
  end

endmodule

/* tb_dem_uart.sv */
`timescale 1ns/1ns

module tb_dem_uart;

  import dii_pkg::*;
  import dem_uart_pkg::*;

  localparam int        CLK_PERIOD  = 10;
  localparam int        N_TESTS     = 5;
  localparam int        TEST_CYCLES = 1500;            // longest test, twenty packets with stalls.
  localparam int        N_TX        = 20;
  localparam int        WAIT_LIMIT  = 100;             // cycles for one handshake.
  localparam dii_word_t TB_ID       = 16'h3c5a;

  typedef dii_flit [DII_PKT_LEN-1:0] pkt_t;            // flit 0 leaves first.

  logic        clk;
  logic        rst_i;
  dii_flit     debug_in;
  logic        debug_in_ready;
  dii_flit     debug_out;
  logic        debug_out_ready = 1'b1;
  logic        irq;
  logic        hsel;
  logic [15:0] haddr;
  logic [31:0] hwdata;
  logic        hwrite;
  logic [1:0]  htrans;
  logic [31:0] hrdata;
  logic        hready;
  logic        hresp;

  int          seed = 32'hb157_35be;
  int          errors;
  int          checks;
  int          tests;
  uart_char_t  chars [N_TX + 5];                       // tx chars, then rx and disabled ones.
  dii_flit     exp_q [$];
  dii_flit     got_q [$];

  tb_clkgen u_clkgen (.clk_o(clk), .rst_o(rst_i));

  dem_uart_ahb3 uut (
    .clk (clk), .rst_i (rst_i), .id_i (TB_ID),
    .debug_in_i (debug_in), .debug_in_ready_o (debug_in_ready),
    .debug_out_o (debug_out), .debug_out_ready_i (debug_out_ready),
    .irq_o (irq),
    .ahb3_hsel_i (hsel), .ahb3_haddr_i (haddr), .ahb3_hwdata_i (hwdata),
    .ahb3_hwrite_i (hwrite), .ahb3_htrans_i (htrans),
    .ahb3_hrdata_o (hrdata), .ahb3_hready_o (hready), .ahb3_hresp_o (hresp)
  );

  bind dem_uart_16550 dem_uart_properties u_props (
    .clk (clk), .rst_i (rst_i), .bus_ack_i (bus_ack_o), .out_valid_i (out_valid_o),
    .out_ready_i (out_ready_i), .drop_i (drop_i), .irq_i (irq_o)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic pkt_t ref_packet(input uart_char_t c, input dii_word_t src);
    pkt_t p;
    p[0] = {1'b1, 1'b0, DII_HOST_ID};                  // events always go to the host.
    p[1] = {1'b1, 1'b0, src};
    p[2] = {1'b1, 1'b0, DII_TYPE_EVENT, 8'h00};
    p[3] = {1'b1, 1'b1, 8'h00, c};
    return p;
  endfunction

  // lsr or iir for a given data ready, thr empty and ier.
  function automatic uart_char_t ref_reg(input uart_reg_addr_t addr, input logic dr,
                                         input logic thre, input logic [1:0] ie);
    uart_char_t v;
    v = '0;
    if (addr == REG_LSR) begin
      v[LSR_DR]   = dr;
      v[LSR_THRE] = thre;
    end else if (addr == REG_IIR) begin
      if (ie[0] && dr) v = IIR_RDA;                    // rx data wins.
      else if (ie[1] && thre) v = IIR_THRE;
      else v = IIR_NONE;
    end
    return v;
  endfunction

  task automatic check_char(input string name, input uart_char_t exp, input uart_char_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_flit(input string name, input dii_flit exp, input dii_flit act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error: %s expected %b actual %b", name, exp, act);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus and debug drivers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic bus_xfer(input logic wr, input uart_reg_addr_t addr, input uart_char_t wdata,
                          output uart_char_t rdata);
    int n;
    n     = 0;
    rdata = '0;
    @(posedge clk);
    hsel   <= 1'b1;
    htrans <= 2'b10;                                   // nonseq.
    haddr  <= {11'h000, addr, 2'b00};
    hwrite <= wr;
    hwdata <= {24'h000000, wdata};
    do begin
      @(negedge clk);
      n++;
    end while (!hready && n < WAIT_LIMIT);
    if (!hready) begin
      errors++;
      $display("no acknowledge for access to register %0d", addr);
    end else begin
      rdata = hrdata[7:0];
      if (!wr && (hrdata !== {4{rdata}})) begin        // same byte on every lane.
        errors++;
        $display("read of register %0d not repeated on all four byte lanes", addr);
      end
    end
    @(posedge clk);
    hsel   <= 1'b0;                                    // idle for at least one cycle.
    htrans <= 2'b00;
  endtask

  task automatic send_pkt(input dii_type_t kind, input dii_word_t payload);
    dii_word_t words [DII_PKT_LEN];
    int        n;
    words[0] = TB_ID;
    words[1] = DII_HOST_ID;
    words[2] = {kind, 8'h00};
    words[3] = payload;
    for (int i = 0; i < DII_PKT_LEN; i++) begin
      @(posedge clk);                                  // previous flit transfers here.
      debug_in <= {1'b1, (i == DII_PKT_LEN - 1), words[i]};
      n = 0;
      do begin
        @(negedge clk);
        n++;
      end while (!debug_in_ready && n < WAIT_LIMIT);
      if (!debug_in_ready) begin
        errors++;
        $display("debug_in flit %0d was never accepted", i);
      end
    end
    @(posedge clk);
    debug_in <= '0;
  endtask

  task automatic poll_data_ready(output uart_char_t lsr);
    int n;
    n = 0;
    do begin
      bus_xfer(1'b0, REG_LSR, 8'h00, lsr);
      n++;
    end while (!lsr[LSR_DR] && n < WAIT_LIMIT);
    if (!lsr[LSR_DR]) begin
      errors++;
      $display("received char never set data ready");
    end
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < TEST_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected flits never appeared on debug_out", exp_q.size());
      exp_q.delete();
    end
  endtask

  task automatic finish_test(input string name, input int err_at_start);
    tests++;
    if (errors == err_at_start) $display("test %s: ok", name);
    else $display("test %s: %0d error(s)", name, errors - err_at_start);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // debug_out stall, monitor and compare
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin : stall_out
    forever begin
      @(posedge clk);
      if (rst_i) debug_out_ready <= 1'b1;
      else debug_out_ready <= (($random(seed) & 3) != 0);  // one cycle in four stalls.
    end
  end

  always @(negedge clk) begin
    if (!rst_i && debug_out.valid && debug_out_ready) begin
      got_q.push_back(debug_out);                      // transfers on the next edge.
    end
  end

  initial begin : compare_flits
    dii_flit exp_f;
    forever begin
      @(posedge clk);
      while (got_q.size() != 0) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("unexpected flit %h on debug_out", got_q.pop_front());
        end else begin
          exp_f = exp_q.pop_front();
          check_flit("event flit", exp_f, got_q.pop_front());
        end
      end
    end
  end

  initial begin : watchdog
    #(N_TESTS * TEST_CYCLES * 2 * CLK_PERIOD);
    $display("watchdog expired, the run did not finish in time");
    $display("sim failed");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin : stimulus
    uart_char_t rd;
    pkt_t       pkt;
    int         e0;
    int         n;
    hsel     = 1'b0;
    haddr    = '0;
    hwdata   = '0;
    hwrite   = 1'b0;
    htrans   = 2'b00;
    debug_in = '0;
    for (int i = 0; i < N_TX + 5; i++) begin
      chars[i] = uart_char_t'($random(seed));
    end
    do begin
      @(negedge clk);
    end while (rst_i !== 1'b0);

    e0 = errors;                                       // reset state, engine disabled.
    bus_xfer(1'b0, REG_LSR, 8'h00, rd);
    check_char("reset lsr", ref_reg(REG_LSR, 1'b0, 1'b1, 2'b00), rd);
    bus_xfer(1'b0, REG_IIR, 8'h00, rd);
    check_char("reset iir", ref_reg(REG_IIR, 1'b0, 1'b1, 2'b00), rd);
    @(negedge clk);
    check_bit("reset irq", 1'b0, irq);
    check_bit("hresp okay", 1'b0, hresp);
    bus_xfer(1'b1, REG_RBR_THR, 8'h5a, rd);
    repeat (20) @(negedge clk);
    bus_xfer(1'b0, REG_LSR, 8'h00, rd);
    check_char("dropped lsr", ref_reg(REG_LSR, 1'b0, 1'b1, 2'b00), rd);
    finish_test("reset", e0);

    e0 = errors;                                       // enable, then twenty chars out.
    send_pkt(DII_TYPE_CTRL, 16'h0001);
    for (int i = 0; i < N_TX; i++) begin
      pkt = ref_packet(chars[i], TB_ID);
      for (int k = 0; k < DII_PKT_LEN; k++) begin
        exp_q.push_back(pkt[k]);
      end
      bus_xfer(1'b1, REG_RBR_THR, chars[i], rd);
    end
    wait_drained();
    finish_test("transmit", e0);

    e0 = errors;
    send_pkt(DII_TYPE_EVENT, {8'h00, chars[N_TX]});
    poll_data_ready(rd);
    check_char("rx lsr", ref_reg(REG_LSR, 1'b1, 1'b1, 2'b00), rd);
    bus_xfer(1'b0, REG_RBR_THR, 8'h00, rd);
    check_char("rx rbr", chars[N_TX], rd);
    bus_xfer(1'b0, REG_LSR, 8'h00, rd);
    check_char("rx lsr cleared", ref_reg(REG_LSR, 1'b0, 1'b1, 2'b00), rd);
    finish_test("receive", e0);

    e0 = errors;
    bus_xfer(1'b1, REG_IER, 8'h01, rd);                // rx data interrupt only.
    send_pkt(DII_TYPE_EVENT, {8'h00, chars[N_TX + 1]});
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!irq && n < WAIT_LIMIT);
    check_bit("rda irq", ref_reg(REG_IIR, 1'b1, 1'b1, 2'b01) != IIR_NONE, irq);
    bus_xfer(1'b0, REG_IIR, 8'h00, rd);
    check_char("rda iir", ref_reg(REG_IIR, 1'b1, 1'b1, 2'b01), rd);
    bus_xfer(1'b0, REG_RBR_THR, 8'h00, rd);
    check_char("rda rbr", chars[N_TX + 1], rd);
    bus_xfer(1'b1, REG_IER, 8'h02, rd);                // thr empty interrupt only.
    bus_xfer(1'b0, REG_IIR, 8'h00, rd);
    check_char("thre iir", ref_reg(REG_IIR, 1'b0, 1'b1, 2'b10), rd);
    @(negedge clk);
    check_bit("thre irq", ref_reg(REG_IIR, 1'b0, 1'b1, 2'b10) != IIR_NONE, irq);
    bus_xfer(1'b1, REG_IER, 8'h00, rd);
    finish_test("interrupt", e0);

    e0 = errors;                                       // disable, writes still acknowledged.
    send_pkt(DII_TYPE_CTRL, 16'h0000);
    for (int i = N_TX + 2; i < N_TX + 5; i++) begin
      bus_xfer(1'b1, REG_RBR_THR, chars[i], rd);
    end
    repeat (20) @(negedge clk);
    bus_xfer(1'b0, REG_LSR, 8'h00, rd);
    check_char("disabled lsr", ref_reg(REG_LSR, 1'b0, 1'b1, 2'b00), rd);
    finish_test("disable", e0);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
